//--- dcache.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_port0_if.sv
verilog/dcache_memory.sv
verilog/dcache_port0_arbiter.sv
verilog/dcache_hit_check.sv
verilog/dcache_load_ctrl.sv
verilog/dcache_store_ctrl.sv
verilog/dcache_top.sv
dv/dcache_tb.sv

//--- dv/dcache_tb.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_tb
    import dcache_pkg::*;
();

    logic     clk_i;
    logic     rst_n_i;
    logic     load_req_i;
    addr_t    load_addr_i;
    word_t    load_data_o;
    logic     load_valid_o;
    logic     load_idle_o;
    logic     store_req_i;
    addr_t    store_addr_i;
    word_t    store_data_i;
    byte_en_t store_be_i;
    logic     store_done_o;
    logic     store_idle_o;
    logic     ldu_mem_req_o;
    addr_t    ldu_mem_addr_o;
    word_t    ldu_mem_data_i;
    logic     ldu_mem_valid_i;
    logic     stu_mem_req_o;
    addr_t    stu_mem_addr_o;
    word_t    stu_mem_data_o;
    byte_en_t stu_mem_be_o;
    logic     stu_mem_ack_i;

    // Expected values for the checks below
    int       errors = 0;
    int       tests_run = 0;
    logic     exp_miss;
    logic     refill_seen;
    word_t    exp_load_data;
    addr_t    exp_refill_addr;
    addr_t    exp_st_addr;
    word_t    exp_st_data;
    byte_en_t exp_st_be;

    // External memory and reference tag state
    logic [31:0] lfsr_q = 32'hb66e;
    word_t       mem_words [addr_t];
    logic        ref_valid [`DC_WAYS][`DC_SETS];
    tag_t        ref_tag   [`DC_WAYS][`DC_SETS];
    logic        ref_rr    [`DC_SETS];
    logic        refill_active = 1'b0;
    int          refill_wait;
    int          refill_cnt;
    logic        wr_active = 1'b0;
    int          wr_wait;

    dcache_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < count; i++) begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    // Untouched words get random contents on first access
    function automatic word_t mem_word(input addr_t addr);
        addr_t aligned;
        aligned = {addr[31:2], 2'b00};
        if (!mem_words.exists(aligned)) begin
            mem_words[aligned] = lfsr_bits(32);
        end
        return mem_words[aligned];
    endfunction

    task automatic apply_write(input addr_t addr, input word_t data, input byte_en_t be);
        word_t word;
        word = mem_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        mem_words[{addr[31:2], 2'b00}] = word;
    endtask

    // Predicts hit or miss and installs a missing line in the first invalid or round-robin way
    function automatic logic predict_miss(input addr_t addr);
        tag_t   tag;
        index_t idx;
        logic   hit;
        int     victim;
        tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
        idx = addr[7:4];
        hit = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) hit = 1'b1;
        end
        if (!hit) begin
            if (!ref_valid[0][idx]) begin
                victim = 0;
            end else if (!ref_valid[1][idx]) begin
                victim = 1;
            end else begin
                victim = ref_rr[idx] ? 1 : 0;
                ref_rr[idx] = !ref_rr[idx];
            end
            ref_valid[victim][idx] = 1'b1;
            ref_tag[victim][idx] = tag;
        end
        return !hit;
    endfunction

    // ------------------------------------------------------------
    // Memory model with refill strobes and write acknowledge
    // ------------------------------------------------------------
    always begin
        @(posedge clk_i);
        #5;
        ldu_mem_valid_i = 1'b0;
        if (ldu_mem_req_o && !refill_active) begin
            refill_active = 1'b1;
            refill_seen = 1'b1;
            refill_wait = int'(lfsr_bits(2));
            refill_cnt = 0;
        end else if (refill_active) begin
            if (refill_wait != 0) begin
                refill_wait--;
            end else begin
                ldu_mem_valid_i = 1'b1;
                ldu_mem_data_i = mem_word(ldu_mem_addr_o + addr_t'(4 * refill_cnt));
                refill_cnt++;
                if (refill_cnt == 4) refill_active = 1'b0;
            end
        end
    end

    always begin
        @(posedge clk_i);
        #5;
        stu_mem_ack_i = 1'b0;
        if (stu_mem_req_o && !wr_active) begin
            wr_active = 1'b1;
            wr_wait = int'(lfsr_bits(2));
        end else if (wr_active) begin
            if (wr_wait != 0) begin
                wr_wait--;
            end else begin
                apply_write(stu_mem_addr_o, stu_mem_data_o, stu_mem_be_o);
                stu_mem_ack_i = 1'b1;
                wr_active = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    a_reset_state: assert property (@(posedge clk_i) !rst_n_i |=> (load_idle_o && store_idle_o
            && !load_valid_o && !store_done_o && !ldu_mem_req_o && !stu_mem_req_o))
        else begin
            errors++;
            $display("Control outputs not in their reset state at time %0t", $time);
        end

    a_load_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            load_valid_o |-> load_data_o == exp_load_data)
        else begin
            errors++;
            $display("Mismatch at %0t: load_data_o got %h expected %h",
                     $time, $sampled(load_data_o), exp_load_data);
        end

    a_refill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            load_valid_o |-> refill_seen == exp_miss)
        else begin
            errors++;
            $display("Mismatch at %0t: ldu_mem_req_o refill got %0b expected %0b",
                     $time, $sampled(refill_seen), exp_miss);
        end

    a_refill_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            ldu_mem_req_o |-> ldu_mem_addr_o == exp_refill_addr)
        else begin
            errors++;
            $display("Mismatch at %0t: ldu_mem_addr_o got %h expected %h",
                     $time, $sampled(ldu_mem_addr_o), exp_refill_addr);
        end

    // Hit answers on the third edge after the request edge
    a_hit_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $past(load_req_i && load_idle_o, 4) && !exp_miss |-> load_valid_o)
        else begin
            errors++;
            $display("Load hit did not raise load_valid_o 3 cycles after the request at %0t",
                     $time);
        end

    a_store_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            stu_mem_req_o |-> stu_mem_addr_o == exp_st_addr)
        else begin
            errors++;
            $display("Mismatch at %0t: stu_mem_addr_o got %h expected %h",
                     $time, $sampled(stu_mem_addr_o), exp_st_addr);
        end

    a_store_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            stu_mem_req_o |-> stu_mem_data_o == exp_st_data && stu_mem_be_o == exp_st_be)
        else begin
            errors++;
            $display("Mismatch at %0t: stu_mem_data_o/be got %h/%b expected %h/%b", $time,
                     $sampled(stu_mem_data_o), $sampled(stu_mem_be_o), exp_st_data, exp_st_be);
        end

    // ------------------------------------------------------------
    // Request tasks
    // ------------------------------------------------------------
    task automatic load_check(input addr_t addr);
        int wait_cnt;
        exp_miss        = predict_miss(addr);
        exp_load_data   = mem_word(addr);
        exp_refill_addr = {addr[31:4], 4'b0000};
        refill_seen     = 1'b0;
        load_addr_i     = addr;
        load_req_i      = 1'b1;
        @(posedge clk_i);
        #5;
        load_req_i = 1'b0;
        wait_cnt = 0;
        while (!load_valid_o && wait_cnt < 200) begin
            @(posedge clk_i);
            #5;
            wait_cnt++;
        end
        if (!load_valid_o) begin
            errors++;
            $display("Load of %h timed out waiting for load_valid_o", addr);
        end
        @(posedge clk_i);
        #5;
    endtask

    task automatic store_check(input addr_t addr, input word_t data, input byte_en_t be);
        int wait_cnt;
        exp_st_addr  = addr;
        exp_st_data  = data;
        exp_st_be    = be;
        store_addr_i = addr;
        store_data_i = data;
        store_be_i   = be;
        store_req_i  = 1'b1;
        @(posedge clk_i);
        #5;
        store_req_i = 1'b0;
        wait_cnt = 0;
        while (!store_done_o && wait_cnt < 200) begin
            @(posedge clk_i);
            #5;
            wait_cnt++;
        end
        if (!store_done_o) begin
            errors++;
            $display("Store to %h timed out waiting for store_done_o", addr);
        end
        @(posedge clk_i);
        #5;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        int errs_before;
        rst_n_i         = 1'b0;
        load_req_i      = 1'b0;
        load_addr_i     = '0;
        store_req_i     = 1'b0;
        store_addr_i    = '0;
        store_data_i    = '0;
        store_be_i      = '0;
        ldu_mem_data_i  = '0;
        ldu_mem_valid_i = 1'b0;
        stu_mem_ack_i   = 1'b0;
        for (int s = 0; s < `DC_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_rr[s] = 1'b0;
        end
        repeat (16) @(posedge clk_i);
        #5;
        rst_n_i = 1'b1;

        errs_before = errors;
        load_check(32'h0000_1000);
        report_test("reset and first load", errs_before);

        errs_before = errors;
        load_check(32'h0000_2008);
        load_check(32'h0000_200c);
        report_test("load miss then hit", errs_before);

        errs_before = errors;
        store_check(32'h0000_2004, 32'ha1b2_c3d4, 4'b0101);
        load_check(32'h0000_2004);
        report_test("store hit partial bytes", errs_before);

        errs_before = errors;
        store_check(32'h0000_3010, 32'h5566_7788, 4'b1110);
        load_check(32'h0000_3010);
        report_test("store miss no allocate", errs_before);

        // All lines share index 5 and the third one evicts the first
        errs_before = errors;
        load_check(32'h0001_0050);
        load_check(32'h0002_0054);
        load_check(32'h0003_0058);
        load_check(32'h0002_005c);
        load_check(32'h0001_0050);
        report_test("replacement", errs_before);

        // Store enters port 0 while the load refill is finishing
        errs_before = errors;
        fork
            load_check(32'h0004_0088);
            begin : store_side
                int strobe_cnt;
                int wait_cnt;
                strobe_cnt = 0;
                wait_cnt = 0;
                while (strobe_cnt < 3 && wait_cnt < 200) begin
                    @(posedge clk_i);
                    if (ldu_mem_valid_i) strobe_cnt++;
                    wait_cnt++;
                end
                if (strobe_cnt < 3) begin
                    errors++;
                    $display("Timed out waiting for refill strobes before the store");
                end
                #5;
                store_check(32'h0000_2000, 32'hdead_beef, 4'b0011);
            end
        join
        load_check(32'h0004_0080);
        load_check(32'h0000_2000);
        report_test("concurrent load and store", errs_before);

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module dcache_tb -f dcache.f -o dcache_sim &&
./obj_dir/dcache_sim | grep "All tests passed!" ||
{ echo "Simulation did not pass"; exit 1; }

//--- verilog/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ------------------------------------------------------------
// Address and data widths
// ------------------------------------------------------------
`define DC_ADDR_W      32
`define DC_WORD_W      32

// Cache geometry, 2 ways x 16 sets x 4 words
`define DC_WAYS        2
`define DC_SETS        16
`define DC_LINE_WORDS  4

// Address split, tag | index | word select | byte offset
`define DC_INDEX_W     4
`define DC_WSEL_W      2
`define DC_BYTE_OFF_W  2
`define DC_TAG_W       24

`endif

//--- verilog/dcache_hit_check.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_hit_check
    import dcache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  tag_t  [`DC_WAYS-1:0]      tags_i,
    input  way_t                      valid_i,
    input  word_t [`DC_WAYS-1:0]      words_i,
    input  tag_t                      addr_tag_i,
    output logic                      hit_o,
    output way_t                      way_hit_o,
    output word_t                     word_o
);

    way_t  way_match;
    word_t word_sel;

    // Compare every valid way against the address tag
    always_comb begin
        word_sel = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_match[w] = valid_i[w] && (tags_i[w] == addr_tag_i);
            if (way_match[w]) begin
                word_sel = words_i[w];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= |way_match;
        end
    end

    always_ff @(posedge clk_i) begin
        way_hit_o <= way_match;
        word_o    <= word_sel;
    end

endmodule

//--- verilog/dcache_load_ctrl.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_load_ctrl
    import dcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    // Load side
    input  logic                load_req_i,
    input  addr_t               load_addr_i,
    output word_t               load_data_o,
    output logic                load_valid_o,
    output logic                load_idle_o,
    // Port 1 and its hit check
    output logic                p1_rd_o,
    output index_t              p1_index_o,
    output wsel_t               p1_wsel_o,
    output tag_t                addr_tag_o,
    input  logic                hit_i,
    input  word_t               hit_word_i,
    // Port 0, used for the victim read and the line fill
    dcache_port0_if.requester   p0,
    input  way_t                p0_valid_i,
    // Refill from external memory
    output logic                mem_req_o,
    output addr_t               mem_addr_o,
    input  word_t               mem_data_i,
    input  logic                mem_valid_i
);

    load_state_t           state_q;
    wsel_t                 cnt_q;
    logic                  chk_wait_q;
    logic                  vict_rd_q;
    logic                  vict_ok_q;
    logic                  use_rr_q;
    logic [`DC_SETS-1:0]   rr_q;
    addr_t                 addr_q;
    line_t                 line_q;
    word_t                 data_q;
    way_t                  way_q;
    way_t                  victim;
    index_t                index;
    wsel_t                 wsel;

    assign addr_tag_o = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index      = addr_q[`DC_BYTE_OFF_W + `DC_WSEL_W +: `DC_INDEX_W];
    assign wsel       = addr_q[`DC_BYTE_OFF_W +: `DC_WSEL_W];

    // First invalid way, else the set's round-robin pointer
    always_comb begin
        if (!p0_valid_i[0]) begin
            victim = 2'b01;
        end else if (!p0_valid_i[1]) begin
            victim = 2'b10;
        end else begin
            victim = rr_q[index] ? 2'b10 : 2'b01;
        end
    end

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= LD_IDLE;
            cnt_q      <= '0;
            chk_wait_q <= 1'b0;
            vict_rd_q  <= 1'b0;
            vict_ok_q  <= 1'b0;
            use_rr_q   <= 1'b0;
            rr_q       <= '0;
        end else begin
            case (state_q)
                LD_IDLE: if (load_req_i) state_q <= LD_LOOKUP;
                LD_LOOKUP: state_q <= LD_CHECK;
                LD_CHECK: begin
                    // Array read plus registered compare takes two cycles
                    chk_wait_q <= !chk_wait_q;
                    if (chk_wait_q) begin
                        state_q <= hit_i ? LD_RESPOND : LD_FETCH;
                    end
                end
                LD_FETCH: begin
                    if (mem_valid_i) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == '1) state_q <= LD_FILL;
                    end
                end
                LD_FILL: begin
                    if (!vict_ok_q) begin
                        if (vict_rd_q) begin
                            vict_rd_q <= 1'b0;
                            vict_ok_q <= 1'b1;
                            use_rr_q  <= &p0_valid_i;
                        end else if (p0.gnt) begin
                            vict_rd_q <= 1'b1;
                        end
                    end else if (p0.gnt) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == '1) begin
                            vict_ok_q <= 1'b0;
                            if (use_rr_q) rr_q[index] <= !rr_q[index];
                            state_q <= LD_RESPOND;
                        end
                    end
                end
                default: state_q <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == LD_IDLE && load_req_i) addr_q <= load_addr_i;
        if (state_q == LD_CHECK && chk_wait_q) data_q <= hit_word_i;
        if (state_q == LD_FETCH && mem_valid_i) line_q[cnt_q] <= mem_data_i;
        if (state_q == LD_FILL && vict_rd_q) way_q <= victim;
        if (state_q == LD_FILL && vict_ok_q && p0.gnt && cnt_q == '1) begin
            data_q <= line_q[wsel];
        end
    end

    // Port 0 requests, a tag read first and then one write per word
    assign p0.req     = (state_q == LD_FILL) && !vict_rd_q;
    assign p0.rd      = !vict_ok_q;
    assign p0.wr      = vict_ok_q;
    assign p0.way_en  = way_q;
    assign p0.index   = index;
    assign p0.tag     = addr_tag_o;
    assign p0.wsel    = cnt_q;
    assign p0.byte_en = '1;
    assign p0.wdata   = line_q[cnt_q];

    assign p1_rd_o    = (state_q == LD_LOOKUP);
    assign p1_index_o = index;
    assign p1_wsel_o  = wsel;

    assign mem_req_o  = (state_q == LD_FETCH);
    assign mem_addr_o = {addr_tag_o, index, {(`DC_WSEL_W + `DC_BYTE_OFF_W){1'b0}}};

    assign load_valid_o = (state_q == LD_RESPOND);
    assign load_data_o  = data_q;
    assign load_idle_o  = (state_q == LD_IDLE);

endmodule

//--- verilog/dcache_memory.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_memory
    import dcache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Port 0, write and tag read
    dcache_port0_if.array             p0,
    output tag_t  [`DC_WAYS-1:0]      p0_tags_o,
    output way_t                      p0_valid_o,
    // Port 1, read only
    input  logic                      p1_rd_i,
    input  index_t                    p1_index_i,
    input  wsel_t                     p1_wsel_i,
    output tag_t  [`DC_WAYS-1:0]      p1_tags_o,
    output way_t                      p1_valid_o,
    output word_t [`DC_WAYS-1:0]      p1_words_o
);

    tag_t  tag_mem  [`DC_WAYS][`DC_SETS];
    word_t data_mem [`DC_WAYS][`DC_SETS][`DC_LINE_WORDS];

    // Valid bits live in flops so that reset can clear them
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (p0.wr && p0.way_en[w]) begin
                    valid_q[w][p0.index] <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Arrays and registered read data
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (p0.wr && p0.way_en[w]) begin
                tag_mem[w][p0.index] <= p0.tag;
                for (int b = 0; b < `DC_WORD_W/8; b++) begin
                    if (p0.byte_en[b]) begin
                        data_mem[w][p0.index][p0.wsel][8*b +: 8] <= p0.wdata[8*b +: 8];
                    end
                end
            end
            if (p0.rd) begin
                p0_tags_o[w]  <= tag_mem[w][p0.index];
                p0_valid_o[w] <= valid_q[w][p0.index];
            end
            if (p1_rd_i) begin
                p1_tags_o[w]  <= tag_mem[w][p1_index_i];
                p1_valid_o[w] <= valid_q[w][p1_index_i];
                p1_words_o[w] <= data_mem[w][p1_index_i][p1_wsel_i];
            end
        end
    end

endmodule

//--- verilog/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    // Vectors with a meaning of their own
    typedef logic [`DC_ADDR_W-1:0]     addr_t;
    typedef logic [`DC_WORD_W-1:0]     word_t;
    typedef logic [`DC_TAG_W-1:0]      tag_t;
    typedef logic [`DC_INDEX_W-1:0]    index_t;
    typedef logic [`DC_WSEL_W-1:0]     wsel_t;
    typedef logic [`DC_WORD_W/8-1:0]   byte_en_t;
    typedef logic [`DC_WAYS-1:0]       way_t;
    typedef word_t [`DC_LINE_WORDS-1:0] line_t;

    // Controller state machines
    typedef enum logic [2:0] {
        LD_IDLE, LD_LOOKUP, LD_CHECK, LD_FETCH, LD_FILL, LD_RESPOND
    } load_state_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_CHECK, ST_WRITE, ST_MEMORY, ST_DONE
    } store_state_t;

endpackage

//--- verilog/dcache_port0_arbiter.sv
`timescale 1ns/10ps

module dcache_port0_arbiter
    import dcache_pkg::*;
(
    dcache_port0_if.arbiter_side ldu,
    dcache_port0_if.arbiter_side stu,
    dcache_port0_if.requester    mem_p0
);

    // Store side always wins
    assign stu.gnt = stu.req;
    assign ldu.gnt = ldu.req && !stu.req;

    always_comb begin
        if (stu.req) begin
            mem_p0.rd      = stu.rd;
            mem_p0.wr      = stu.wr;
            mem_p0.way_en  = stu.way_en;
            mem_p0.index   = stu.index;
            mem_p0.tag     = stu.tag;
            mem_p0.wsel    = stu.wsel;
            mem_p0.byte_en = stu.byte_en;
            mem_p0.wdata   = stu.wdata;
        end else begin
            // No grant at all means no access
            mem_p0.rd      = ldu.req && ldu.rd;
            mem_p0.wr      = ldu.req && ldu.wr;
            mem_p0.way_en  = ldu.way_en;
            mem_p0.index   = ldu.index;
            mem_p0.tag     = ldu.tag;
            mem_p0.wsel    = ldu.wsel;
            mem_p0.byte_en = ldu.byte_en;
            mem_p0.wdata   = ldu.wdata;
        end
    end

endmodule

//--- verilog/dcache_port0_if.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

// One requester's access to the shared read/write port of the array
interface dcache_port0_if;
    logic                      req;
    logic                      gnt;
    logic                      rd;
    logic                      wr;
    logic [`DC_WAYS-1:0]       way_en;
    logic [`DC_INDEX_W-1:0]    index;
    logic [`DC_TAG_W-1:0]      tag;
    logic [`DC_WSEL_W-1:0]     wsel;
    logic [`DC_WORD_W/8-1:0]   byte_en;
    logic [`DC_WORD_W-1:0]     wdata;

    modport requester (output req, rd, wr, way_en, index, tag, wsel, byte_en, wdata,
                       input gnt);
    modport arbiter_side (input req, rd, wr, way_en, index, tag, wsel, byte_en, wdata,
                          output gnt);
    modport array (input rd, wr, way_en, index, tag, wsel, byte_en, wdata);
endinterface

//--- verilog/dcache_store_ctrl.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_store_ctrl
    import dcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    // Store side
    input  logic                store_req_i,
    input  addr_t               store_addr_i,
    input  word_t               store_data_i,
    input  byte_en_t            store_be_i,
    output logic                store_done_o,
    output logic                store_idle_o,
    // Port 0 and its hit check
    dcache_port0_if.requester   p0,
    input  logic                hit_i,
    input  way_t                way_hit_i,
    // Write-through to external memory
    output logic                mem_req_o,
    output addr_t               mem_addr_o,
    output word_t               mem_data_o,
    output byte_en_t            mem_be_o,
    input  logic                mem_ack_i
);

    store_state_t state_q;
    logic         chk_wait_q;
    addr_t        addr_q;
    word_t        data_q;
    byte_en_t     be_q;
    way_t         way_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            chk_wait_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE:   if (store_req_i) state_q <= ST_LOOKUP;
                ST_LOOKUP: if (p0.gnt) state_q <= ST_CHECK;
                ST_CHECK: begin
                    chk_wait_q <= !chk_wait_q;
                    // Miss skips the array, no allocate
                    if (chk_wait_q) state_q <= hit_i ? ST_WRITE : ST_MEMORY;
                end
                ST_WRITE:  if (p0.gnt) state_q <= ST_MEMORY;
                ST_MEMORY: if (mem_ack_i) state_q <= ST_DONE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && store_req_i) begin
            addr_q <= store_addr_i;
            data_q <= store_data_i;
            be_q   <= store_be_i;
        end
        if (state_q == ST_CHECK && chk_wait_q) way_q <= way_hit_i;
    end

    // ------------------------------------------------------------
    // Port 0, tag lookup then byte write into the hitting way
    // ------------------------------------------------------------
    assign p0.req     = (state_q == ST_LOOKUP) || (state_q == ST_WRITE);
    assign p0.rd      = (state_q == ST_LOOKUP);
    assign p0.wr      = (state_q == ST_WRITE);
    assign p0.way_en  = way_q;
    assign p0.index   = addr_q[`DC_BYTE_OFF_W + `DC_WSEL_W +: `DC_INDEX_W];
    assign p0.tag     = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign p0.wsel    = addr_q[`DC_BYTE_OFF_W +: `DC_WSEL_W];
    assign p0.byte_en = be_q;
    assign p0.wdata   = data_q;

    assign mem_req_o  = (state_q == ST_MEMORY);
    assign mem_addr_o = addr_q;
    assign mem_data_o = data_q;
    assign mem_be_o   = be_q;

    assign store_done_o = (state_q == ST_DONE);
    assign store_idle_o = (state_q == ST_IDLE);

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    // Load side
    input  logic      load_req_i,
    input  addr_t     load_addr_i,
    output word_t     load_data_o,
    output logic      load_valid_o,
    output logic      load_idle_o,
    // Store side
    input  logic      store_req_i,
    input  addr_t     store_addr_i,
    input  word_t     store_data_i,
    input  byte_en_t  store_be_i,
    output logic      store_done_o,
    output logic      store_idle_o,
    // Load refill
    output logic      ldu_mem_req_o,
    output addr_t     ldu_mem_addr_o,
    input  word_t     ldu_mem_data_i,
    input  logic      ldu_mem_valid_i,
    // Store write-through
    output logic      stu_mem_req_o,
    output addr_t     stu_mem_addr_o,
    output word_t     stu_mem_data_o,
    output byte_en_t  stu_mem_be_o,
    input  logic      stu_mem_ack_i
);

    dcache_port0_if ldu_p0 ();
    dcache_port0_if stu_p0 ();
    dcache_port0_if mem_p0 ();

    tag_t  [`DC_WAYS-1:0] p0_tags;
    way_t                 p0_valid;
    logic                 p0_hit;
    way_t                 p0_way_hit;
    logic                 p1_rd;
    index_t               p1_index;
    wsel_t                p1_wsel;
    tag_t  [`DC_WAYS-1:0] p1_tags;
    way_t                 p1_valid;
    word_t [`DC_WAYS-1:0] p1_words;
    tag_t                 ldu_tag;
    logic                 p1_hit;
    word_t                p1_hit_word;

    dcache_memory u_memory (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .p0         (mem_p0),
        .p0_tags_o  (p0_tags),
        .p0_valid_o (p0_valid),
        .p1_rd_i    (p1_rd),
        .p1_index_i (p1_index),
        .p1_wsel_i  (p1_wsel),
        .p1_tags_o  (p1_tags),
        .p1_valid_o (p1_valid),
        .p1_words_o (p1_words)
    );

    dcache_port0_arbiter u_arbiter (
        .ldu    (ldu_p0),
        .stu    (stu_p0),
        .mem_p0 (mem_p0)
    );

    // Port 0 check serves the store lookup and carries no data word
    dcache_hit_check u_p0_hit (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .tags_i     (p0_tags),
        .valid_i    (p0_valid),
        .words_i    ('0),
        .addr_tag_i (stu_p0.tag),
        .hit_o      (p0_hit),
        .way_hit_o  (p0_way_hit),
        .word_o     ()
    );

    dcache_hit_check u_p1_hit (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .tags_i     (p1_tags),
        .valid_i    (p1_valid),
        .words_i    (p1_words),
        .addr_tag_i (ldu_tag),
        .hit_o      (p1_hit),
        .way_hit_o  (),
        .word_o     (p1_hit_word)
    );

    dcache_load_ctrl u_load_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_req_i   (load_req_i),
        .load_addr_i  (load_addr_i),
        .load_data_o  (load_data_o),
        .load_valid_o (load_valid_o),
        .load_idle_o  (load_idle_o),
        .p1_rd_o      (p1_rd),
        .p1_index_o   (p1_index),
        .p1_wsel_o    (p1_wsel),
        .addr_tag_o   (ldu_tag),
        .hit_i        (p1_hit),
        .hit_word_i   (p1_hit_word),
        .p0           (ldu_p0),
        .p0_valid_i   (p0_valid),
        .mem_req_o    (ldu_mem_req_o),
        .mem_addr_o   (ldu_mem_addr_o),
        .mem_data_i   (ldu_mem_data_i),
        .mem_valid_i  (ldu_mem_valid_i)
    );

    dcache_store_ctrl u_store_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .store_req_i  (store_req_i),
        .store_addr_i (store_addr_i),
        .store_data_i (store_data_i),
        .store_be_i   (store_be_i),
        .store_done_o (store_done_o),
        .store_idle_o (store_idle_o),
        .p0           (stu_p0),
        .hit_i        (p0_hit),
        .way_hit_i    (p0_way_hit),
        .mem_req_o    (stu_mem_req_o),
        .mem_addr_o   (stu_mem_addr_o),
        .mem_data_o   (stu_mem_data_o),
        .mem_be_o     (stu_mem_be_o),
        .mem_ack_i    (stu_mem_ack_i)
    );

endmodule
